// ==== verilog/secv_pkg.sv ====
// Shared widths, opcodes, ALU and instruction-format types of the core, used by scoped names
`default_nettype none

package secv_pkg;

    // Datapath and instruction widths
    localparam int XLEN       = 64;
    localparam int ILEN       = 32;
    localparam int REG_ADR_W  = 5;

    // Word address widths of the two memory ports
    localparam int IMEM_ADR_W = 8;
    localparam int DMEM_ADR_W = 8;
    localparam int DMEM_SEL_W = 8;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Funct3 codes, ALU group
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Funct3 codes, memory and branch groups
    localparam logic [2:0] F3_DW  = 3'b011;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Immediate field of EBREAK under OPC_SYSTEM
    localparam logic [11:0] F12_EBREAK = 12'h001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        IC_ALU,
        IC_LOAD,
        IC_STORE,
        IC_BRANCH,
        IC_JAL,
        IC_HALT,
        IC_NOP
    } iclass_t;

    // Instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, six views
    typedef union packed {
        logic [ILEN-1:0] raw;
        r_fmt_t          r_fmt;
        i_fmt_t          i_fmt;
        s_fmt_t          s_fmt;
        b_fmt_t          b_fmt;
        u_fmt_t          u_fmt;
        j_fmt_t          j_fmt;
    } inst_u;

    // ADDI x0,x0,0
    localparam logic [ILEN-1:0] INST_NOP = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== verilog/secv_decode.sv ====
// Combinational decoder turning the instruction register into operand, ALU and class fields
`timescale 1ns/1ps
`default_nettype none

module secv_decode (
    input  secv_pkg::inst_u                inst_i,
    output logic [secv_pkg::REG_ADR_W-1:0] rs1_adr_o,
    output logic [secv_pkg::REG_ADR_W-1:0] rs2_adr_o,
    output logic [secv_pkg::REG_ADR_W-1:0] rd_adr_o,
    output logic [secv_pkg::XLEN-1:0]      imm_o,
    output logic                           imm_use_o,
    output secv_pkg::alu_op_t              alu_op_o,
    output secv_pkg::iclass_t              iclass_o,
    output logic                           brn_ne_o
);
    localparam int XL = secv_pkg::XLEN;

    logic [XL-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // Sign-extended immediates per format
    assign imm_i = {{(XL-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
    assign imm_s = {{(XL-12){inst_i.s_fmt.imm11_5[6]}}, inst_i.s_fmt.imm11_5,
                    inst_i.s_fmt.imm4_0};
    assign imm_b = {{(XL-13){inst_i.b_fmt.imm12}}, inst_i.b_fmt.imm12, inst_i.b_fmt.imm11,
                    inst_i.b_fmt.imm10_5, inst_i.b_fmt.imm4_1, 1'b0};
    assign imm_u = {{(XL-32){inst_i.u_fmt.imm31_12[19]}}, inst_i.u_fmt.imm31_12, 12'b0};
    assign imm_j = {{(XL-21){inst_i.j_fmt.imm20}}, inst_i.j_fmt.imm20, inst_i.j_fmt.imm19_12,
                    inst_i.j_fmt.imm11, inst_i.j_fmt.imm10_1, 1'b0};

    // BEQ and BNE differ in funct3 only
    assign brn_ne_o = (inst_i.b_fmt.funct3 == secv_pkg::F3_BNE);

    always_comb begin
        rs1_adr_o = inst_i.r_fmt.rs1;
        rs2_adr_o = inst_i.r_fmt.rs2;
        rd_adr_o  = inst_i.r_fmt.rd;
        imm_o     = '0;
        imm_use_o = 1'b0;
        alu_op_o  = secv_pkg::ALU_ADD;
        iclass_o  = secv_pkg::IC_NOP;

        case (inst_i.r_fmt.opcode)
            secv_pkg::OPC_LUI: begin
                // Immediate passes straight through the ALU
                imm_o     = imm_u;
                imm_use_o = 1'b1;
                alu_op_o  = secv_pkg::ALU_PASS_B;
                iclass_o  = secv_pkg::IC_ALU;
            end
            secv_pkg::OPC_OPIMM: begin
                imm_o     = imm_i;
                imm_use_o = 1'b1;
                iclass_o  = secv_pkg::IC_ALU;
                case (inst_i.i_fmt.funct3)
                    secv_pkg::F3_ADD: alu_op_o = secv_pkg::ALU_ADD;
                    secv_pkg::F3_SLT: alu_op_o = secv_pkg::ALU_SLT;
                    secv_pkg::F3_XOR: alu_op_o = secv_pkg::ALU_XOR;
                    secv_pkg::F3_OR:  alu_op_o = secv_pkg::ALU_OR;
                    secv_pkg::F3_AND: alu_op_o = secv_pkg::ALU_AND;
                    // Immediate shifts and SLTIU are not supported
                    default:          iclass_o = secv_pkg::IC_NOP;
                endcase
            end
            secv_pkg::OPC_OP: begin
                iclass_o = secv_pkg::IC_ALU;
                case (inst_i.r_fmt.funct3)
                    // Instruction bit 30 selects SUB
                    secv_pkg::F3_ADD: alu_op_o = inst_i.r_fmt.funct7[5] ? secv_pkg::ALU_SUB
                                                                        : secv_pkg::ALU_ADD;
                    secv_pkg::F3_SLL: alu_op_o = secv_pkg::ALU_SLL;
                    secv_pkg::F3_SLT: alu_op_o = secv_pkg::ALU_SLT;
                    secv_pkg::F3_XOR: alu_op_o = secv_pkg::ALU_XOR;
                    secv_pkg::F3_SRL: alu_op_o = secv_pkg::ALU_SRL;
                    secv_pkg::F3_OR:  alu_op_o = secv_pkg::ALU_OR;
                    secv_pkg::F3_AND: alu_op_o = secv_pkg::ALU_AND;
                    default:          iclass_o = secv_pkg::IC_NOP;
                endcase
            end
            secv_pkg::OPC_LOAD: begin
                // ALU forms rs1 + imm as effective address
                if (inst_i.i_fmt.funct3 == secv_pkg::F3_DW) begin
                    imm_o     = imm_i;
                    imm_use_o = 1'b1;
                    iclass_o  = secv_pkg::IC_LOAD;
                end
            end
            secv_pkg::OPC_STORE: begin
                if (inst_i.s_fmt.funct3 == secv_pkg::F3_DW) begin
                    imm_o     = imm_s;
                    imm_use_o = 1'b1;
                    iclass_o  = secv_pkg::IC_STORE;
                end
            end
            secv_pkg::OPC_BRANCH: begin
                // Offset goes to pc; rs1 and rs2 compared in the core
                if (inst_i.b_fmt.funct3 == secv_pkg::F3_BEQ || brn_ne_o) begin
                    imm_o    = imm_b;
                    iclass_o = secv_pkg::IC_BRANCH;
                end
            end
            secv_pkg::OPC_JAL: begin
                imm_o    = imm_j;
                iclass_o = secv_pkg::IC_JAL;
            end
            secv_pkg::OPC_SYSTEM: begin
                if (inst_i.i_fmt.imm == secv_pkg::F12_EBREAK &&
                    inst_i.i_fmt.funct3 == 3'b000) begin
                    iclass_o = secv_pkg::IC_HALT;
                end
            end
            default: begin
                iclass_o = secv_pkg::IC_NOP;
            end
        endcase

        // No write back for anything unknown
        if (iclass_o == secv_pkg::IC_NOP) begin
            rd_adr_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/secv_gpr.sv ====
// General purpose register file, two async read ports and one sync write port
`timescale 1ns/1ps
`default_nettype none

module secv_gpr (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic [secv_pkg::REG_ADR_W-1:0] rs1_adr_i,
    input  logic [secv_pkg::REG_ADR_W-1:0] rs2_adr_i,
    output logic [secv_pkg::XLEN-1:0]      rs1_dat_o,
    output logic [secv_pkg::XLEN-1:0]      rs2_dat_o,
    input  logic [secv_pkg::REG_ADR_W-1:0] rd_adr_i,
    input  logic [secv_pkg::XLEN-1:0]      rd_dat_i,
    input  logic                           rd_wb_i
);
    logic [secv_pkg::XLEN-1:0] regs [2**secv_pkg::REG_ADR_W];

    // Write port; x0 never written so it keeps its reset zero
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 2**secv_pkg::REG_ADR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wb_i && rd_adr_i != '0) begin
            regs[rd_adr_i] <= rd_dat_i;
        end
    end

    // Read ports
    assign rs1_dat_o = regs[rs1_adr_i];
    assign rs2_dat_o = regs[rs2_adr_i];

    // x0 reads as zero from reset on
    a_x0_rs1: assert property (@(posedge clk_i) disable iff (rst_i)
        rs1_adr_i == '0 |-> rs1_dat_o == '0);
    a_x0_rs2: assert property (@(posedge clk_i) disable iff (rst_i)
        rs2_adr_i == '0 |-> rs2_dat_o == '0);

endmodule

`default_nettype wire

// ==== verilog/secv_alu.sv ====
// 64-bit combinational ALU for the integer register and immediate operations
`timescale 1ns/1ps
`default_nettype none

module secv_alu (
    input  secv_pkg::alu_op_t         op_i,
    input  logic [secv_pkg::XLEN-1:0] a_i,
    input  logic [secv_pkg::XLEN-1:0] b_i,
    output logic [secv_pkg::XLEN-1:0] res_o
);
    logic [5:0] shamt;
    logic       lt;

    // Six-bit shift amount for RV64
    assign shamt = b_i[5:0];

    // Signed compare for SLT and SLTI
    assign lt = ($signed(a_i) < $signed(b_i));

    always_comb begin
        case (op_i)
            secv_pkg::ALU_ADD: res_o = a_i + b_i;
            secv_pkg::ALU_SUB: res_o = a_i - b_i;
            secv_pkg::ALU_SLT: res_o = {{(secv_pkg::XLEN-1){1'b0}}, lt};
            secv_pkg::ALU_XOR: res_o = a_i ^ b_i;
            secv_pkg::ALU_OR:  res_o = a_i | b_i;
            secv_pkg::ALU_AND: res_o = a_i & b_i;
            secv_pkg::ALU_SLL: res_o = a_i << shamt;
            // Logical right shift, zero fill
            secv_pkg::ALU_SRL: res_o = a_i >> shamt;
            // LUI result is the U immediate itself
            secv_pkg::ALU_PASS_B: res_o = b_i;
            default:           res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/secv_lsu.sv ====
// Wishbone classic data-port master for aligned doubleword loads and stores
`timescale 1ns/1ps
`default_nettype none

module secv_lsu (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            start_i,
    input  logic                            we_i,
    input  logic [secv_pkg::XLEN-1:0]       adr_i,
    input  logic [secv_pkg::XLEN-1:0]       wdat_i,
    output logic [secv_pkg::XLEN-1:0]       rdat_o,
    output logic                            done_o,
    output logic                            dmem_cyc_o,
    output logic                            dmem_stb_o,
    output logic                            dmem_we_o,
    output logic [secv_pkg::DMEM_ADR_W-1:0] dmem_adr_o,
    output logic [secv_pkg::DMEM_SEL_W-1:0] dmem_sel_o,
    output logic [secv_pkg::XLEN-1:0]       dmem_dat_o,
    input  logic [secv_pkg::XLEN-1:0]       dmem_dat_i,
    input  logic                            dmem_ack_i
);
    logic busy;

    // Request open from the cycle after start until ack
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy <= 1'b0;
        end else if (start_i) begin
            busy <= 1'b1;
        end else if (dmem_ack_i) begin
            busy <= 1'b0;
        end
    end

    // Request payload held stable for the whole transfer
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            dmem_we_o  <= we_i;
            // Doubleword index, bits 2..0 are the byte offset
            dmem_adr_o <= adr_i[secv_pkg::DMEM_ADR_W+2:3];
            dmem_dat_o <= wdat_i;
        end
    end

    // Load data captured in the ack cycle
    always_ff @(posedge clk_i) begin
        if (busy && dmem_ack_i && !dmem_we_o) begin
            rdat_o <= dmem_dat_i;
        end
    end

    assign dmem_cyc_o = busy;
    assign dmem_stb_o = busy;
    // Whole doubleword only
    assign dmem_sel_o = '1;
    assign done_o     = busy && dmem_ack_i;

    // Request held steady until acknowledged
    a_stb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_stb_o && !dmem_ack_i |=> dmem_stb_o && $stable(dmem_adr_o)
                                       && $stable(dmem_we_o) && $stable(dmem_dat_o));

    // FSM starts one access at a time
    a_no_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> !dmem_cyc_o);

endmodule

`default_nettype wire

// ==== verilog/secv.sv ====
// Multicycle RV64I-subset core: main FSM, fetch port and datapath around the units
`timescale 1ns/1ps
`default_nettype none

module secv (
    input  logic                            clk_i,
    input  logic                            rst_i,
    output logic                            imem_cyc_o,
    output logic                            imem_stb_o,
    output logic [secv_pkg::IMEM_ADR_W-1:0] imem_adr_o,
    input  logic [secv_pkg::ILEN-1:0]       imem_dat_i,
    input  logic                            imem_ack_i,
    output logic                            dmem_cyc_o,
    output logic                            dmem_stb_o,
    output logic                            dmem_we_o,
    output logic [secv_pkg::DMEM_ADR_W-1:0] dmem_adr_o,
    output logic [secv_pkg::DMEM_SEL_W-1:0] dmem_sel_o,
    output logic [secv_pkg::XLEN-1:0]       dmem_dat_o,
    input  logic [secv_pkg::XLEN-1:0]       dmem_dat_i,
    input  logic                            dmem_ack_i,
    output logic                            halted_o
);
    localparam int XL = secv_pkg::XLEN;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WB,
        ST_HALT
    } state_t;

    state_t          state;
    logic [XL-1:0]   pc, pc_next, pc_link, pc_target;
    secv_pkg::inst_u ir;
    logic [XL-1:0]   op_a, op_b, res;
    logic            mem_start;

    // Decoder outputs
    logic [secv_pkg::REG_ADR_W-1:0] rs1_adr, rs2_adr, rd_adr;
    logic [XL-1:0]                  imm;
    logic                           imm_use, brn_ne;
    secv_pkg::alu_op_t              alu_op;
    secv_pkg::iclass_t              iclass;

    // Datapath nets
    logic [XL-1:0] rs1_dat, rs2_dat, rd_dat, alu_b, alu_res, lsu_rdat;
    logic          rd_wb, is_mem, brn_take, lsu_done;

    secv_decode dec_i (
        .inst_i    (ir),
        .rs1_adr_o (rs1_adr),
        .rs2_adr_o (rs2_adr),
        .rd_adr_o  (rd_adr),
        .imm_o     (imm),
        .imm_use_o (imm_use),
        .alu_op_o  (alu_op),
        .iclass_o  (iclass),
        .brn_ne_o  (brn_ne)
    );

    secv_gpr gpr_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs1_adr_i (rs1_adr),
        .rs2_adr_i (rs2_adr),
        .rs1_dat_o (rs1_dat),
        .rs2_dat_o (rs2_dat),
        .rd_adr_i  (rd_adr),
        .rd_dat_i  (rd_dat),
        .rd_wb_i   (rd_wb)
    );

    // B operand is the immediate or rs2
    assign alu_b = imm_use ? imm : rs2_dat;

    secv_alu alu_i (
        .op_i  (alu_op),
        .a_i   (rs1_dat),
        .b_i   (alu_b),
        .res_o (alu_res)
    );

    // Address from the latched ALU sum, store data from rs2
    secv_lsu lsu_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .start_i    (mem_start),
        .we_i       (iclass == secv_pkg::IC_STORE),
        .adr_i      (res),
        .wdat_i     (op_b),
        .rdat_o     (lsu_rdat),
        .done_o     (lsu_done),
        .dmem_cyc_o (dmem_cyc_o),
        .dmem_stb_o (dmem_stb_o),
        .dmem_we_o  (dmem_we_o),
        .dmem_adr_o (dmem_adr_o),
        .dmem_sel_o (dmem_sel_o),
        .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i),
        .dmem_ack_i (dmem_ack_i)
    );

    assign is_mem = (iclass == secv_pkg::IC_LOAD) || (iclass == secv_pkg::IC_STORE);

    // Branch and jump resolution
    assign pc_link   = pc + XL'(4);
    assign pc_target = pc + imm;
    assign brn_take  = (iclass == secv_pkg::IC_BRANCH) && ((op_a == op_b) != brn_ne);
    assign pc_next   = (brn_take || iclass == secv_pkg::IC_JAL) ? pc_target : pc_link;

    // Write-back source and enable
    always_comb begin
        case (iclass)
            secv_pkg::IC_LOAD: rd_dat = lsu_rdat;
            secv_pkg::IC_JAL:  rd_dat = pc_link;
            default:           rd_dat = res;
        endcase
    end
    assign rd_wb = (state == ST_WB) && (iclass == secv_pkg::IC_ALU ||
                   iclass == secv_pkg::IC_LOAD || iclass == secv_pkg::IC_JAL);

    // Fetch port, word address from pc
    assign imem_cyc_o = (state == ST_FETCH);
    assign imem_stb_o = (state == ST_FETCH);
    assign imem_adr_o = pc[secv_pkg::IMEM_ADR_W+1:2];
    assign halted_o   = (state == ST_HALT);

    // Main FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state     <= ST_IDLE;
            pc        <= '0;
            ir.raw    <= secv_pkg::INST_NOP;
            mem_start <= 1'b0;
        end else begin
            mem_start <= 1'b0;
            case (state)
                ST_IDLE: state <= ST_FETCH;
                ST_FETCH: begin
                    // Stay until the instruction arrives
                    if (imem_ack_i) begin
                        ir.raw <= imem_dat_i;
                        state  <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    // Strobe to the LSU in the first EXECUTE cycle
                    mem_start <= is_mem;
                    state     <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    if (!is_mem || lsu_done) begin
                        state <= ST_WB;
                    end
                end
                ST_WB: begin
                    pc    <= pc_next;
                    state <= (iclass == secv_pkg::IC_HALT) ? ST_HALT : ST_FETCH;
                end
                // Halted for good, no more requests
                ST_HALT: state <= ST_HALT;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operands and ALU result latched in DECODE
    always_ff @(posedge clk_i) begin
        if (state == ST_DECODE) begin
            op_a <= rs1_dat;
            op_b <= rs2_dat;
            res  <= alu_res;
        end
    end

    // Fetch request held with a steady address until ack
    a_imem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_stb_o && !imem_ack_i |=> imem_stb_o && imem_cyc_o && $stable(imem_adr_o));

endmodule

`default_nettype wire

// ==== tests/secv_mem.sv ====
// Wishbone memory model for the fetch and data ports, with random wait states and preloaded data
`timescale 1ns/1ps
`default_nettype none

module secv_mem (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            imem_cyc_i,
    input  logic                            imem_stb_i,
    input  logic [secv_pkg::IMEM_ADR_W-1:0] imem_adr_i,
    output logic [secv_pkg::ILEN-1:0]       imem_dat_o = '0,
    output logic                            imem_ack_o = 1'b0,
    input  logic                            dmem_cyc_i,
    input  logic                            dmem_stb_i,
    input  logic                            dmem_we_i,
    input  logic [secv_pkg::DMEM_ADR_W-1:0] dmem_adr_i,
    input  logic [secv_pkg::XLEN-1:0]       dmem_dat_i,
    output logic [secv_pkg::XLEN-1:0]       dmem_dat_o = '0,
    output logic                            dmem_ack_o = 1'b0
);
    // Program words, written by the testbench
    logic [secv_pkg::ILEN-1:0] imem [2**secv_pkg::IMEM_ADR_W];
    logic [secv_pkg::XLEN-1:0] dmem [2**secv_pkg::DMEM_ADR_W];

    logic [15:0] lfsr = 16'd87;
    logic        preloaded = 1'b0;
    logic [63:0] pre_word;
    logic [1:0]  wait_n;
    logic [1:0]  icnt, dcnt;
    logic        ipend, dpend;

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One bit out, one step
    task automatic take_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            imem_ack_o <= 1'b0;
            dmem_ack_o <= 1'b0;
            ipend      <= 1'b0;
            dpend      <= 1'b0;
            icnt       <= '0;
            dcnt       <= '0;
            if (!preloaded) begin
                // Address-dependent fill, then four random doublewords at the bottom
                for (int i = 0; i < 2**secv_pkg::DMEM_ADR_W; i++) begin
                    dmem[i] <= {8{i[7:0]}};
                end
                for (int w = 0; w < 4; w++) begin
                    for (int b = 0; b < 64; b++) begin
                        take_bit(pre_word[b]);
                    end
                    dmem[w] <= pre_word;
                end
                preloaded = 1'b1;
            end
        end else begin
            imem_ack_o <= 1'b0;
            dmem_ack_o <= 1'b0;

            // Fetch port, 0 to 3 wait cycles
            if (imem_cyc_i && imem_stb_i && !imem_ack_o) begin
                if (!ipend) begin
                    take_bit(wait_n[1]);
                    take_bit(wait_n[0]);
                    icnt  <= wait_n;
                    ipend <= 1'b1;
                end else if (icnt == 2'd0) begin
                    imem_ack_o <= 1'b1;
                    imem_dat_o <= imem[imem_adr_i];
                    ipend      <= 1'b0;
                end else begin
                    icnt <= icnt - 2'd1;
                end
            end

            // Data port, store lands in the ack cycle
            if (dmem_cyc_i && dmem_stb_i && !dmem_ack_o) begin
                if (!dpend) begin
                    take_bit(wait_n[1]);
                    take_bit(wait_n[0]);
                    dcnt  <= wait_n;
                    dpend <= 1'b1;
                end else if (dcnt == 2'd0) begin
                    dmem_ack_o <= 1'b1;
                    dpend      <= 1'b0;
                    if (dmem_we_i) begin
                        dmem[dmem_adr_i] <= dmem_dat_i;
                    end else begin
                        dmem_dat_o <= dmem[dmem_adr_i];
                    end
                end else begin
                    dcnt <= dcnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/secv_tb.sv ====
// Testbench top: runs a fixed program on the core and checks every store against rule values
`timescale 1ns/1ps
`default_nettype none

module secv_tb;
    localparam int STORE_TIMEOUT = 400;
    localparam int HALT_TIMEOUT  = 400;

    logic                            clk_i;
    logic                            rst_i;
    logic                            imem_cyc, imem_stb, imem_ack;
    logic [secv_pkg::IMEM_ADR_W-1:0] imem_adr;
    logic [secv_pkg::ILEN-1:0]       imem_dat;
    logic                            dmem_cyc, dmem_stb, dmem_we, dmem_ack;
    logic [secv_pkg::DMEM_ADR_W-1:0] dmem_adr;
    logic [secv_pkg::DMEM_SEL_W-1:0] dmem_sel;
    logic [secv_pkg::XLEN-1:0]       dmem_wdat, dmem_rdat;
    logic                            halted;

    // Expected and observed stores
    logic [secv_pkg::DMEM_ADR_W-1:0] exp_adr [$];
    logic [secv_pkg::XLEN-1:0]       exp_dat [$];
    logic [secv_pkg::DMEM_ADR_W-1:0] got_adr [$];
    logic [secv_pkg::XLEN-1:0]       got_dat [$];
    logic [secv_pkg::DMEM_SEL_W-1:0] got_sel [$];
    int                              pc_cur;

    secv dut_i (
        .clk_i (clk_i), .rst_i (rst_i),
        .imem_cyc_o (imem_cyc), .imem_stb_o (imem_stb), .imem_adr_o (imem_adr),
        .imem_dat_i (imem_dat), .imem_ack_i (imem_ack),
        .dmem_cyc_o (dmem_cyc), .dmem_stb_o (dmem_stb), .dmem_we_o (dmem_we),
        .dmem_adr_o (dmem_adr), .dmem_sel_o (dmem_sel), .dmem_dat_o (dmem_wdat),
        .dmem_dat_i (dmem_rdat), .dmem_ack_i (dmem_ack),
        .halted_o (halted)
    );

    secv_mem mem_i (
        .clk_i (clk_i), .rst_i (rst_i),
        .imem_cyc_i (imem_cyc), .imem_stb_i (imem_stb), .imem_adr_i (imem_adr),
        .imem_dat_o (imem_dat), .imem_ack_o (imem_ack),
        .dmem_cyc_i (dmem_cyc), .dmem_stb_i (dmem_stb), .dmem_we_i (dmem_we),
        .dmem_adr_i (dmem_adr), .dmem_dat_i (dmem_wdat),
        .dmem_dat_o (dmem_rdat), .dmem_ack_o (dmem_ack)
    );

    always #50 clk_i = ~clk_i;

    // Store monitor, one entry per acked write
    always @(posedge clk_i) begin
        if (!rst_i && dmem_cyc && dmem_stb && dmem_we && dmem_ack) begin
            got_adr.push_back(dmem_adr);
            got_dat.push_back(dmem_wdat);
            got_sel.push_back(dmem_sel);
        end
    end

    // Instruction encoders
    function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int opc);
        enc_i = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
        enc_r = {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], secv_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_b(int imm, int rs2, int rs1, int f3);
        enc_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                 secv_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int imm, int rd);
        enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], secv_pkg::OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] inst);
        mem_i.imem[pc_cur[9:2]] = inst;
        pc_cur += 4;
    endtask

    // SD rs to the next result slot, byte 128 up
    task automatic store(input int rs, input logic [63:0] exp);
        int n;
        int off;
        n = exp_adr.size();
        off = 128 + 8 * n;
        emit({off[11:5], rs[4:0], 5'd0, secv_pkg::F3_DW, off[4:0], secv_pkg::OPC_STORE});
        exp_adr.push_back(8'(16 + n));
        exp_dat.push_back(exp);
    endtask

    // Store that must never execute
    task automatic poison();
        emit({7'd62, 5'd1, 5'd0, secv_pkg::F3_DW, 5'd16, secv_pkg::OPC_STORE});
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_adr(input string name, input logic [secv_pkg::DMEM_ADR_W-1:0] got,
                             input logic [secv_pkg::DMEM_ADR_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_dat(input string name, input logic [secv_pkg::XLEN-1:0] got,
                             input logic [secv_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_sel(input string name, input logic [secv_pkg::DMEM_SEL_W-1:0] got,
                             input logic [secv_pkg::DMEM_SEL_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic wait_store();
        int cyc;
        cyc = 0;
        while (got_adr.size() == 0) begin
            if (cyc == STORE_TIMEOUT) begin
                stop_run("Timed out waiting for a store");
            end
            @(posedge clk_i);
            cyc++;
        end
    endtask

    task automatic wait_halt();
        int cyc;
        cyc = 0;
        while (!halted) begin
            if (cyc == HALT_TIMEOUT) begin
                stop_run("Core did not halt after EBREAK");
            end
            @(posedge clk_i);
            cyc++;
        end
    endtask

    // Program and expected stores
    task automatic build_program();
        longint a;
        logic [63:0] d0, d1, d2, d3;
        int jal_pc;
        a  = -5;
        d0 = mem_i.dmem[0];
        d1 = mem_i.dmem[1];
        d2 = mem_i.dmem[2];
        d3 = mem_i.dmem[3];
        // Harmless ADDI x0 fill, immediate from the address
        for (int i = 0; i < 256; i++) begin
            mem_i.imem[i] = enc_i(i, 0, 0, 0, secv_pkg::OPC_OPIMM);
        end
        pc_cur = 0;
        // Immediate forms
        emit(enc_i(-5, 0, secv_pkg::F3_ADD, 1, secv_pkg::OPC_OPIMM));
        store(1, a);
        emit(enc_i(240, 1, secv_pkg::F3_OR, 2, secv_pkg::OPC_OPIMM));
        store(2, a | 240);
        emit(enc_i(-1, 1, secv_pkg::F3_XOR, 3, secv_pkg::OPC_OPIMM));
        store(3, a ^ -1);
        emit(enc_i(2035, 1, secv_pkg::F3_AND, 4, secv_pkg::OPC_OPIMM));
        store(4, a & 2035);
        emit(enc_i(-4, 1, secv_pkg::F3_SLT, 5, secv_pkg::OPC_OPIMM));
        store(5, (a < -4) ? 64'd1 : 64'd0);
        emit(enc_i(-6, 1, secv_pkg::F3_SLT, 6, secv_pkg::OPC_OPIMM));
        store(6, (a < -6) ? 64'd1 : 64'd0);
        emit({20'h80001, 5'd7, secv_pkg::OPC_LUI});
        store(7, longint'(int'(32'h8000_1000)));
        // Loads, then register forms
        for (int w = 0; w < 4; w++) begin
            emit(enc_i(8 * w, 0, secv_pkg::F3_DW, 8 + w, secv_pkg::OPC_LOAD));
        end
        store(8, d0);
        emit(enc_r(0, 9, 8, secv_pkg::F3_ADD, 12));
        store(12, d0 + d1);
        emit(enc_r(32, 9, 8, secv_pkg::F3_ADD, 12));
        store(12, d0 - d1);
        emit(enc_r(0, 9, 8, secv_pkg::F3_SLT, 12));
        store(12, ($signed(d0) < $signed(d1)) ? 64'd1 : 64'd0);
        emit(enc_r(0, 9, 8, secv_pkg::F3_AND, 12));
        store(12, d0 & d1);
        emit(enc_r(0, 10, 8, secv_pkg::F3_OR, 12));
        store(12, d0 | d2);
        emit(enc_r(0, 11, 9, secv_pkg::F3_XOR, 12));
        store(12, d1 ^ d3);
        emit(enc_r(0, 10, 8, secv_pkg::F3_SLL, 12));
        store(12, d0 << d2[5:0]);
        emit(enc_r(0, 11, 9, secv_pkg::F3_SRL, 12));
        store(12, d1 >> d3[5:0]);
        // Taken BEQ, not-taken BEQ, taken BNE, not-taken BNE
        emit(enc_b(8, 0, 0, secv_pkg::F3_BEQ));
        poison();
        emit(enc_b(8, 0, 1, secv_pkg::F3_BEQ));
        store(2, a | 240);
        emit(enc_b(8, 0, 1, secv_pkg::F3_BNE));
        poison();
        emit(enc_b(8, 0, 0, secv_pkg::F3_BNE));
        store(3, a ^ -1);
        // JAL over two poisoned stores, link is its own address plus 4
        jal_pc = pc_cur;
        emit(enc_j(12, 13));
        poison();
        poison();
        store(13, 64'(jal_pc + 4));
        // x0 stays zero
        emit(enc_i(123, 0, secv_pkg::F3_ADD, 0, secv_pkg::OPC_OPIMM));
        store(0, 64'd0);
        emit(enc_i(1, 0, 0, 0, secv_pkg::OPC_SYSTEM));
    endtask

    initial begin
        clk_i = 1'b0;
        rst_i = 1'b1;
        // Preload lands on the first reset edge
        @(posedge clk_i);
        #1;
        build_program();
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        for (int k = 0; k < exp_adr.size(); k++) begin
            wait_store();
            check_adr("dmem_adr_o", got_adr.pop_front(), exp_adr[k]);
            check_dat("dmem_dat_o", got_dat.pop_front(), exp_dat[k]);
            // Whole doubleword on every store
            check_sel("dmem_sel_o", got_sel.pop_front(), {secv_pkg::DMEM_SEL_W{1'b1}});
        end

        wait_halt();
        repeat (20) begin
            @(posedge clk_i);
            if (imem_stb || dmem_stb) begin
                stop_run("Memory request seen after halt");
            end
        end
        if (got_adr.size() != 0) begin
            stop_run("Unexpected extra store seen");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/secv_pkg.sv
verilog/secv_decode.sv
verilog/secv_gpr.sv
verilog/secv_alu.sv
verilog/secv_lsu.sv
verilog/secv.sv
tests/secv_mem.sv
tests/secv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the simulation with Verilator and run it; exit status is the result

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module secv_tb -f src.f -o secv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/secv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi

exit 0
